// File: sw_cfg_pkg.sv
package sw_cfg_pkg;

    // ************************************************************
    // switch sizes.
    // ************************************************************
    localparam int NUM_PORTS         = 4;
    localparam int NUM_PRIOS         = 4;
    localparam int DATA_W            = 16;
    localparam int PAGE_WORDS        = 8;
    localparam int NUM_PAGES         = 64;
    localparam int MAX_PKT_WORDS     = 64;
    localparam int MAX_PKT_PAGES     = 8;
    // free-page count below which the buffer reports almost full.
    localparam int ALMOST_FULL_PAGES = 32;

    // ************************************************************
    // scalar types.
    // ************************************************************
    typedef logic [$clog2(NUM_PORTS)-1:0]      port_t;
    typedef logic [$clog2(NUM_PRIOS)-1:0]      prio_t;
    typedef logic [$clog2(NUM_PAGES)-1:0]      page_t;
    typedef logic [$clog2(PAGE_WORDS)-1:0]     offset_t;
    typedef logic [$clog2(MAX_PKT_WORDS+1)-1:0] len_t;
    typedef logic [DATA_W-1:0]                 word_t;
    typedef logic [$clog2(NUM_PAGES+1)-1:0]    page_count_t;

endpackage

// File: sw_bus_pkg.sv
package sw_bus_pkg;

    // one beat on a write or a read port.
    typedef struct packed {
        logic              sop;
        logic              eop;
        logic              vld;
        sw_cfg_pkg::word_t data;
    } pkt_beat_t;

    // one word on its way into the page buffer.
    typedef struct packed {
        logic                vld;
        sw_cfg_pkg::page_t   page;
        sw_cfg_pkg::offset_t offset;
        sw_cfg_pkg::word_t   data;
    } buf_wr_t;

    // a stored packet, named by its first page.
    typedef struct packed {
        sw_cfg_pkg::port_t dest;
        sw_cfg_pkg::prio_t prio;
        sw_cfg_pkg::page_t head;
        sw_cfg_pkg::len_t  len;
    } pkt_desc_t;

    typedef enum logic {ING_IDLE, ING_BUSY} ingress_state_t;

    typedef enum logic [1:0] {EGR_IDLE, EGR_DESC, EGR_SEND} egress_state_t;

endpackage

// File: wr_ingress.sv
`timescale 1ns/1ns
module wr_ingress (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  sw_bus_pkg::pkt_beat_t [sw_cfg_pkg::NUM_PORTS-1:0] wr,
    input  logic                                            full,
    output logic [sw_cfg_pkg::NUM_PORTS-1:0]                pause,
    output logic                                            alloc,
    input  sw_cfg_pkg::page_t                               alloc_page,
    output logic                                            link_wr,
    output sw_cfg_pkg::page_t                               link_from,
    output sw_cfg_pkg::page_t                               link_to,
    output sw_bus_pkg::buf_wr_t                             buf_wr,
    output logic                                            enq,
    output sw_bus_pkg::pkt_desc_t                           enq_desc
);
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    ingress_state_t       state;
    port_t                owner;
    port_t                rr_ptr;
    port_t                grant_idx;
    port_t                cur_port;
    logic                 grant_vld;
    logic [NUM_PORTS-1:0] req;
    pkt_beat_t            beat;
    logic                 accept;
    logic                 first_beat;
    logic                 new_page;
    len_t                 wcnt;
    page_t                cur_page;
    page_t                head_page;
    port_t                dest_q;
    prio_t                prio_q;

    // ************************************************************
    // input grant.
    // ************************************************************
    // a new packet starts only while a full-size packet still fits.
    always_comb begin
        port_t idx;
        for (int i = 0; i < NUM_PORTS; i++) begin
            req[i] = wr[i].sop && wr[i].vld && !full;
        end
        grant_vld = 1'b0;
        grant_idx = rr_ptr;
        // the input just after the last grant wins ties.
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = rr_ptr + port_t'(i);
            if (req[idx]) begin
                grant_vld = 1'b1;
                grant_idx = idx;
            end
        end
    end

    assign cur_port   = (state == ING_BUSY) ? owner : grant_idx;
    assign beat       = wr[cur_port];
    assign accept     = (state == ING_BUSY) ? beat.vld : grant_vld;
    assign pause      = (state == ING_BUSY || grant_vld) ? ~(NUM_PORTS'(1) << cur_port) : '1;

    // ************************************************************
    // page segmentation.
    // ************************************************************
    assign first_beat = (wcnt == '0);
    assign new_page   = accept && (offset_t'(wcnt) == '0);
    assign alloc      = new_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ING_IDLE;
            owner      <= '0;
            rr_ptr     <= '0;
            wcnt       <= '0;
            buf_wr.vld <= 1'b0;
            link_wr    <= 1'b0;
            enq        <= 1'b0;
        end else begin
            if (state == ING_IDLE && grant_vld) begin
                owner  <= grant_idx;
                rr_ptr <= grant_idx;
            end
            if (accept) begin
                state <= beat.eop ? ING_IDLE : ING_BUSY;
                wcnt  <= beat.eop ? '0 : wcnt + 1'b1;
            end
            buf_wr.vld    <= accept;
            buf_wr.page   <= new_page ? alloc_page : cur_page;
            buf_wr.offset <= offset_t'(wcnt);
            buf_wr.data   <= beat.data;
            // chain the filled page to the one just taken.
            link_wr   <= new_page && !first_beat;
            link_from <= cur_page;
            link_to   <= alloc_page;
            enq       <= accept && beat.eop;
            enq_desc.dest <= first_beat ? port_t'(beat.data[1:0]) : dest_q;
            enq_desc.prio <= first_beat ? prio_t'(beat.data[3:2]) : prio_q;
            enq_desc.head <= first_beat ? alloc_page : head_page;
            enq_desc.len  <= wcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (new_page) begin
            cur_page <= alloc_page;
        end
        if (accept && first_beat) begin
            head_page <= alloc_page;
            dest_q    <= port_t'(beat.data[1:0]);
            prio_q    <= prio_t'(beat.data[3:2]);
        end
    end

endmodule

// File: page_buffer.sv
`timescale 1ns/1ns
module page_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  sw_bus_pkg::buf_wr_t buf_wr,
    input  logic                alloc,
    output sw_cfg_pkg::page_t   alloc_page,
    input  logic                link_wr,
    input  sw_cfg_pkg::page_t   link_from,
    input  sw_cfg_pkg::page_t   link_to,
    input  sw_cfg_pkg::page_t   rd_page,
    input  sw_cfg_pkg::offset_t rd_offset,
    output sw_cfg_pkg::word_t   rd_word,
    output sw_cfg_pkg::page_t   rd_link,
    input  logic                free,
    input  sw_cfg_pkg::page_t   free_page,
    output logic                full,
    output logic                almost_full
);
    import sw_cfg_pkg::*;

    word_t       data_mem [NUM_PAGES*PAGE_WORDS];
    page_t       link_mem [NUM_PAGES];
    page_t       free_fifo [NUM_PAGES];
    page_t       wr_ptr;
    page_t       rd_ptr;
    page_count_t free_cnt;
    page_count_t free_cnt_nxt;

    // ************************************************************
    // data and link memories.
    // ************************************************************
    always_ff @(posedge clk) begin
        if (buf_wr.vld) begin
            data_mem[{buf_wr.page, buf_wr.offset}] <= buf_wr.data;
        end
        if (link_wr) begin
            link_mem[link_from] <= link_to;
        end
        // word and link come back one cycle after the address.
        rd_word <= data_mem[{rd_page, rd_offset}];
        rd_link <= link_mem[rd_page];
    end

    // ************************************************************
    // free-page list.
    // ************************************************************
    assign alloc_page   = free_fifo[rd_ptr];
    assign free_cnt_nxt = free_cnt + page_count_t'(free) - page_count_t'(alloc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // every page starts out free.
            for (int i = 0; i < NUM_PAGES; i++) begin
                free_fifo[i] <= page_t'(i);
            end
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            free_cnt    <= page_count_t'(NUM_PAGES);
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (free) begin
                free_fifo[wr_ptr] <= free_page;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            free_cnt <= free_cnt_nxt;
            // flags follow the count including this cycle's pops.
            full        <= free_cnt_nxt < page_count_t'(MAX_PKT_PAGES);
            almost_full <= free_cnt_nxt < page_count_t'(ALMOST_FULL_PAGES);
        end
    end

endmodule

// File: queue_manager.sv
`timescale 1ns/1ns
module queue_manager (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    enq,
    input  sw_bus_pkg::pkt_desc_t                                   enq_desc,
    input  logic                                                    deq,
    input  sw_cfg_pkg::port_t                                       deq_port,
    input  sw_cfg_pkg::prio_t                                       deq_prio,
    output logic                                                    desc_vld,
    output sw_bus_pkg::pkt_desc_t                                   desc,
    output logic [sw_cfg_pkg::NUM_PORTS-1:0][sw_cfg_pkg::NUM_PRIOS-1:0] nonempty
);
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    // queues are indexed by {port, prio}.
    page_t       q_head [NUM_PORTS*NUM_PRIOS];
    page_t       q_tail [NUM_PORTS*NUM_PRIOS];
    page_count_t q_cnt  [NUM_PORTS*NUM_PRIOS];

    // per-packet storage, indexed by the packet's head page.
    pkt_desc_t desc_mem [NUM_PAGES];
    page_t     next_mem [NUM_PAGES];

    logic [$bits(port_t)+$bits(prio_t)-1:0] eq_idx;
    logic [$bits(port_t)+$bits(prio_t)-1:0] dq_idx;
    logic                                   refill;

    assign eq_idx = {enq_desc.dest, enq_desc.prio};
    assign dq_idx = {deq_port, deq_prio};

    // new packet becomes head on an empty queue or when the last one leaves now.
    assign refill = enq && (q_cnt[eq_idx] == '0 ||
                    (deq && dq_idx == eq_idx && q_cnt[eq_idx] == page_count_t'(1)));

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int r = 0; r < NUM_PRIOS; r++) begin
                nonempty[p][r] = (q_cnt[p*NUM_PRIOS+r] != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            desc_mem[enq_desc.head] <= enq_desc;
            if (q_cnt[eq_idx] != '0) begin
                next_mem[q_tail[eq_idx]] <= enq_desc.head;
            end
        end
        desc <= desc_mem[q_head[dq_idx]];
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            q_head[dq_idx] <= next_mem[q_head[dq_idx]];
        end
        if (refill) begin
            q_head[eq_idx] <= enq_desc.head;
        end
        if (enq) begin
            q_tail[eq_idx] <= enq_desc.head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_vld <= 1'b0;
            for (int q = 0; q < NUM_PORTS*NUM_PRIOS; q++) begin
                q_cnt[q] <= '0;
            end
        end else begin
            desc_vld <= deq;
            for (int q = 0; q < NUM_PORTS*NUM_PRIOS; q++) begin
                q_cnt[q] <= q_cnt[q] + page_count_t'(enq && eq_idx == q)
                                     - page_count_t'(deq && dq_idx == q);
            end
        end
    end

endmodule

// File: rd_egress.sv
`timescale 1ns/1ns
module rd_egress (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [sw_cfg_pkg::NUM_PORTS-1:0]                        ready,
    input  logic [sw_cfg_pkg::NUM_PORTS-1:0][sw_cfg_pkg::NUM_PRIOS-1:0] nonempty,
    output logic                                                    deq,
    output sw_cfg_pkg::port_t                                       deq_port,
    output sw_cfg_pkg::prio_t                                       deq_prio,
    input  logic                                                    desc_vld,
    input  sw_bus_pkg::pkt_desc_t                                   desc,
    output sw_cfg_pkg::page_t                                       rd_page,
    output sw_cfg_pkg::offset_t                                     rd_offset,
    input  sw_cfg_pkg::word_t                                       rd_word,
    input  sw_cfg_pkg::page_t                                       rd_link,
    output logic                                                    free,
    output sw_cfg_pkg::page_t                                       free_page,
    output sw_bus_pkg::pkt_beat_t [sw_cfg_pkg::NUM_PORTS-1:0]       rd
);
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    egress_state_t        state;
    port_t                rr_ptr;
    port_t                cur_port;
    port_t                pick_port;
    prio_t                pick_prio;
    logic                 pick_vld;
    logic [NUM_PORTS-1:0] cand;
    len_t                 remaining;
    logic                 sop_pend;
    logic                 last_word;
    page_t                iss_page;
    offset_t              iss_off;

    // ************************************************************
    // output and priority pick.
    // ************************************************************
    always_comb begin
        port_t idx;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cand[p] = ready[p] && (nonempty[p] != '0);
        end
        pick_vld  = 1'b0;
        pick_port = rr_ptr;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = rr_ptr + port_t'(i);
            if (cand[idx]) begin
                pick_vld  = 1'b1;
                pick_port = idx;
            end
        end
        // strict priority, 0 first.
        pick_prio = '0;
        for (int r = NUM_PRIOS - 1; r >= 0; r--) begin
            if (nonempty[pick_port][r]) begin
                pick_prio = prio_t'(r);
            end
        end
    end

    assign deq      = (state == EGR_IDLE) && pick_vld;
    assign deq_port = pick_port;
    assign deq_prio = pick_prio;

    // ************************************************************
    // page walker.
    // ************************************************************
    // after the last word of a page, the returned link names the next page.
    assign rd_page   = (state == EGR_DESC) ? desc.head : ((iss_off == '1) ? rd_link : iss_page);
    assign rd_offset = (state == EGR_DESC) ? '0 : iss_off + 1'b1;

    always_ff @(posedge clk) begin
        iss_page <= rd_page;
        iss_off  <= rd_offset;
    end

    // iss_* name the word arriving on rd_word in this cycle.
    assign last_word = (remaining == len_t'(1));
    assign free      = (state == EGR_SEND) && (iss_off == '1 || last_word);
    assign free_page = iss_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= EGR_IDLE;
            rr_ptr    <= '0;
            remaining <= '0;
            sop_pend  <= 1'b0;
            rd        <= '0;
        end else begin
            rd <= '0;
            case (state)
                EGR_IDLE: begin
                    if (pick_vld) begin
                        state    <= EGR_DESC;
                        rr_ptr   <= pick_port;
                        cur_port <= pick_port;
                    end
                end
                EGR_DESC: begin
                    if (desc_vld) begin
                        state     <= EGR_SEND;
                        remaining <= desc.len;
                        sop_pend  <= 1'b1;
                    end
                end
                EGR_SEND: begin
                    rd[cur_port].sop  <= sop_pend;
                    rd[cur_port].eop  <= last_word;
                    rd[cur_port].vld  <= 1'b1;
                    rd[cur_port].data <= rd_word;
                    sop_pend  <= 1'b0;
                    remaining <= remaining - 1'b1;
                    if (last_word) begin
                        state <= EGR_IDLE;
                    end
                end
                default: state <= EGR_IDLE;
            endcase
        end
    end

endmodule

// File: sw_top.sv
`timescale 1ns/1ns
module sw_top (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  sw_bus_pkg::pkt_beat_t [sw_cfg_pkg::NUM_PORTS-1:0] wr,
    input  logic [sw_cfg_pkg::NUM_PORTS-1:0]                ready,
    output logic [sw_cfg_pkg::NUM_PORTS-1:0]                pause,
    output logic                                            full,
    output logic                                            almost_full,
    output sw_bus_pkg::pkt_beat_t [sw_cfg_pkg::NUM_PORTS-1:0] rd
);
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    // ingress to buffer and queues.
    logic      alloc;
    page_t     alloc_page;
    logic      link_wr;
    page_t     link_from;
    page_t     link_to;
    buf_wr_t   buf_wr;
    logic      enq;
    pkt_desc_t enq_desc;

    // queues and buffer to egress.
    logic                                 deq;
    port_t                                deq_port;
    prio_t                                deq_prio;
    logic                                 desc_vld;
    pkt_desc_t                            desc;
    logic [NUM_PORTS-1:0][NUM_PRIOS-1:0]  nonempty;
    page_t                                rd_page;
    offset_t                              rd_offset;
    word_t                                rd_word;
    page_t                                rd_link;
    logic                                 free;
    page_t                                free_page;

    wr_ingress u_ingress (
        .clk(clk), .rst_n(rst_n), .wr(wr), .full(full), .pause(pause),
        .alloc(alloc), .alloc_page(alloc_page),
        .link_wr(link_wr), .link_from(link_from), .link_to(link_to),
        .buf_wr(buf_wr), .enq(enq), .enq_desc(enq_desc)
    );

    page_buffer u_buffer (
        .clk(clk), .rst_n(rst_n), .buf_wr(buf_wr),
        .alloc(alloc), .alloc_page(alloc_page),
        .link_wr(link_wr), .link_from(link_from), .link_to(link_to),
        .rd_page(rd_page), .rd_offset(rd_offset), .rd_word(rd_word), .rd_link(rd_link),
        .free(free), .free_page(free_page), .full(full), .almost_full(almost_full)
    );

    queue_manager u_queues (
        .clk(clk), .rst_n(rst_n), .enq(enq), .enq_desc(enq_desc),
        .deq(deq), .deq_port(deq_port), .deq_prio(deq_prio),
        .desc_vld(desc_vld), .desc(desc), .nonempty(nonempty)
    );

    rd_egress u_egress (
        .clk(clk), .rst_n(rst_n), .ready(ready), .nonempty(nonempty),
        .deq(deq), .deq_port(deq_port), .deq_prio(deq_prio),
        .desc_vld(desc_vld), .desc(desc),
        .rd_page(rd_page), .rd_offset(rd_offset), .rd_word(rd_word), .rd_link(rd_link),
        .free(free), .free_page(free_page), .rd(rd)
    );

endmodule

// File: sw_top_assertions.sv
`timescale 1ns/1ns
module sw_top_assertions (
    input logic                                            clk,
    input logic                                            rst_n,
    input logic [sw_cfg_pkg::NUM_PORTS-1:0]                pause,
    input logic                                            full,
    input logic                                            almost_full,
    input sw_bus_pkg::pkt_beat_t [sw_cfg_pkg::NUM_PORTS-1:0] rd
);
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    logic [NUM_PORTS-1:0] rd_sop;
    logic [NUM_PORTS-1:0] rd_eop;
    logic [NUM_PORTS-1:0] rd_vld;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_sop[p] = rd[p].sop;
            rd_eop[p] = rd[p].eop;
            rd_vld[p] = rd[p].vld;
        end
    end

    sop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_sop & ~rd_vld) == '0) else $error("rd_sop without rd_vld");
    eop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_eop & ~rd_vld) == '0) else $error("rd_eop without rd_vld");
    // single read stream.
    one_output: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rd_vld)) else $error("more than one output valid");
    full_in_af: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> almost_full) else $error("full without almost_full");
    one_input: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~pause)) else $error("pause low on more than one input");

endmodule

// File: tb_sw_top.sv
`timescale 1ns/1ns
module tb_sw_top;
    import sw_cfg_pkg::*;
    import sw_bus_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int MAX_PKTS  = 64;
    localparam int FILL_TEST = 3;
    localparam int ARB_TEST  = 5;

    logic                      clk;
    logic                      rst_n;
    pkt_beat_t [NUM_PORTS-1:0] wr = '0;
    logic [NUM_PORTS-1:0]      ready;
    logic [NUM_PORTS-1:0]      pause;
    logic                      full;
    logic                      almost_full;
    pkt_beat_t [NUM_PORTS-1:0] rd;

    // one pattern line per packet.
    int ln_test [MAX_LINES];
    int ln_port [MAX_LINES];
    int ln_dest [MAX_LINES];
    int ln_prio [MAX_LINES];
    int ln_len  [MAX_LINES];
    int ln_af   [MAX_LINES];
    int ln_full [MAX_LINES];
    int n_lines;

    // packet table and per-port bookkeeping.
    word_t pkt_words [MAX_PKTS][MAX_PKT_WORDS];
    int    pkt_len   [MAX_PKTS];
    int    pkt_dest  [MAX_PKTS];
    int    pkt_prio  [MAX_PKTS];
    int    n_pkts;
    int    tx_ids    [NUM_PORTS][$];
    int    exp_ids   [NUM_PORTS*NUM_PRIOS][$];
    int    beat_idx  [NUM_PORTS];
    int    rx_idx    [NUM_PORTS];
    int    rx_q      [NUM_PORTS];
    logic [NUM_PORTS-1:0] pause_seen;
    int    pushed_cnt;
    int    sent_cnt;
    int    recv_cnt;
    int    err_cnt;
    int    check_cnt;
    int    wd_cycles;

    sw_top UUT (
        .clk(clk), .rst_n(rst_n), .wr(wr), .ready(ready), .pause(pause),
        .full(full), .almost_full(almost_full), .rd(rd)
    );

    bind sw_top sw_top_assertions u_checks (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: packets still outstanding after %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // ************************************************************
    // input drivers.
    // ************************************************************
    // a beat moves when vld was high and pause low just before the edge.
    always @(posedge clk) begin
        int id;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr[p].vld && !pause_seen[p]) begin
                id = tx_ids[p][0];
                if (wr[p].eop) begin
                    exp_ids[pkt_dest[id]*NUM_PRIOS + pkt_prio[id]].push_back(id);
                    void'(tx_ids[p].pop_front());
                    beat_idx[p] = 0;
                    sent_cnt++;
                end else begin
                    beat_idx[p]++;
                end
            end
            if (tx_ids[p].size() == 0) begin
                wr[p] <= '0;
            end else begin
                id = tx_ids[p][0];
                wr[p].sop  <= (beat_idx[p] == 0);
                wr[p].eop  <= (beat_idx[p] == pkt_len[id] - 1);
                // bubbles only inside a packet.
                wr[p].vld  <= (beat_idx[p] == 0) || ($urandom_range(3) != 0);
                wr[p].data <= pkt_words[id][beat_idx[p]];
            end
        end
    end

    // ************************************************************
    // output monitor.
    // ************************************************************
    always @(negedge clk) begin
        int q;
        int id;
        pause_seen = pause;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && rd[p].vld) begin
                if (rx_idx[p] == 0) begin
                    // queued packets stay in the buffer while ready is low.
                    assert (ready[p]) else begin
                        $display("%0t ns: output %0d started a packet while its ready was low",
                                 $time, p);
                        err_cnt++;
                    end
                    // strict priority and oldest first within a priority.
                    rx_q[p] = -1;
                    for (int r = NUM_PRIOS - 1; r >= 0; r--) begin
                        q = p * NUM_PRIOS + r;
                        if (exp_ids[q].size() != 0) begin
                            rx_q[p] = q;
                        end
                    end
                    assert (rx_q[p] >= 0) else begin
                        $display("%0t ns: output %0d sent a packet nobody queued for it",
                                 $time, p);
                        err_cnt++;
                    end
                end
                id = (rx_q[p] >= 0) ? exp_ids[rx_q[p]][0] : 0;
                if (rx_q[p] >= 0) begin
                    check_value($sformatf("rd[%0d].data", p), pkt_words[id][rx_idx[p]],
                                rd[p].data);
                    check_value($sformatf("rd[%0d].sop", p), rx_idx[p] == 0, rd[p].sop);
                    check_value($sformatf("rd[%0d].eop", p), rx_idx[p] == pkt_len[id] - 1,
                                rd[p].eop);
                end
                if (rd[p].eop || (rx_q[p] >= 0 && rx_idx[p] == pkt_len[id] - 1)) begin
                    if (rx_q[p] >= 0) begin
                        void'(exp_ids[rx_q[p]].pop_front());
                        recv_cnt++;
                    end
                    rx_idx[p] = 0;
                end else begin
                    rx_idx[p]++;
                end
            end
        end
    end

    task automatic check_value(input string name, input int expv, input int got);
        check_cnt++;
        assert (expv == got) else begin
            $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, expv, got);
            err_cnt++;
        end
    endtask

    task automatic read_patterns();
        int    fd;
        string line;
        fd = $fopen("sw_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file sw_patterns.txt could not be opened");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    if (n_lines < MAX_LINES &&
                        $sscanf(line, "%d %d %d %d %d %d %d", ln_test[n_lines],
                                ln_port[n_lines], ln_dest[n_lines], ln_prio[n_lines],
                                ln_len[n_lines], ln_af[n_lines], ln_full[n_lines]) == 7) begin
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic add_packet(input int port, input int dest, input int prio, input int len);
        int    id;
        word_t hdr;
        id = n_pkts;
        n_pkts++;
        pkt_len[id]  = len;
        pkt_dest[id] = dest;
        pkt_prio[id] = prio;
        hdr          = word_t'($urandom());
        hdr[1:0]     = port_t'(dest);
        hdr[3:2]     = prio_t'(prio);
        pkt_words[id][0] = hdr;
        for (int i = 1; i < len; i++) begin
            pkt_words[id][i] = word_t'($urandom());
        end
        tx_ids[port].push_back(id);
        pushed_cnt++;
    endtask

    task automatic wait_sent();
        while (sent_cnt != pushed_cnt) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic compare_flags(input int ln);
        check_value("almost_full", ln_af[ln], almost_full);
        check_value("full", ln_full[ln], full);
    endtask

    // lines of the arbitration test start together and the others one by one.
    task automatic load_test(input int t);
        for (int i = 0; i < n_lines; i++) begin
            if (ln_test[i] == t) begin
                add_packet(ln_port[i], ln_dest[i], ln_prio[i], ln_len[i]);
                if (t != ARB_TEST) begin
                    wait_sent();
                    compare_flags(i);
                end
            end
        end
        if (t == ARB_TEST) begin
            wait_sent();
            for (int i = 0; i < n_lines; i++) begin
                if (ln_test[i] == t) begin
                    compare_flags(i);
                end
            end
        end
    endtask

    task automatic drain_all();
        @(posedge clk);
        ready <= '1;
        while (recv_cnt != pushed_cnt) @(negedge clk);
        @(posedge clk);
        ready <= '0;
        repeat (3) @(negedge clk);
    endtask

    // one short low-priority packet per input is held back while full.
    task automatic probe_full();
        int sent_before;
        check_value("full", 1, full);
        sent_before = sent_cnt;
        for (int p = 0; p < NUM_PORTS; p++) begin
            add_packet(p, p, NUM_PRIOS - 1, 2);
        end
        repeat (16) begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (wr[p].sop && wr[p].vld) begin
                    check_value($sformatf("pause[%0d]", p), 1, pause[p]);
                end
            end
        end
        check_value("sent packet count", sent_before, sent_cnt);
    endtask

    task automatic report_test(input int t, input string name, input int err_before);
        $display("test %0d %s: %0d errors", t, name, err_cnt - err_before);
    endtask

    initial begin
        int seed_ret;
        int total_len;
        int e0;
        rst_n    = 1'b0;
        ready    = '0;
        seed_ret = $urandom(32'hba53de96);
        read_patterns();
        total_len = 0;
        for (int i = 0; i < n_lines; i++) begin
            total_len += ln_len[i];
        end
        wd_cycles = total_len * 4 + 2000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);

        e0 = err_cnt;
        load_test(1);
        drain_all();
        report_test(1, "priority ordering", e0);

        e0 = err_cnt;
        load_test(2);
        drain_all();
        report_test(2, "data integrity", e0);

        e0 = err_cnt;
        load_test(FILL_TEST);
        probe_full();
        report_test(3, "fill flags", e0);

        // the held probes go out with the drain.
        e0 = err_cnt;
        drain_all();
        check_value("full", 0, full);
        check_value("almost_full", 0, almost_full);
        load_test(4);
        drain_all();
        report_test(4, "recovery", e0);

        e0 = err_cnt;
        load_test(ARB_TEST);
        drain_all();
        report_test(5, "input arbitration", e0);

        $display("tests 5, packets %0d, checks %0d, errors %0d", recv_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sw_patterns.txt
# columns: test input_port dest prio length_words exp_almost_full exp_full
# flags are the values expected once that packet is loaded with ready low.
1 0 1 2 5 0 0
1 1 1 0 9 0 0
1 2 1 3 3 0 0
1 3 1 0 4 0 0
1 0 2 1 12 0 0
1 1 0 3 7 0 0
1 2 3 2 16 0 0
1 3 0 0 8 0 0
2 0 2 0 1 0 0
2 1 3 1 8 0 0
2 2 0 2 9 0 0
2 3 1 3 17 0 0
2 0 3 0 63 0 0
2 1 2 1 64 0 0
3 0 0 1 64 0 0
3 1 1 2 64 0 0
3 2 2 0 64 0 0
3 3 3 1 64 0 0
3 0 1 3 64 1 0
3 1 2 2 64 1 0
3 2 3 0 64 1 0
3 3 0 1 1 1 1
4 2 0 2 64 0 0
5 0 3 1 20 0 0
5 1 2 0 33 0 0
5 2 1 3 6 0 0
5 3 0 2 15 0 0

// File: filelist.f
sw_cfg_pkg.sv
sw_bus_pkg.sv
wr_ingress.sv
page_buffer.sv
queue_manager.sv
rd_egress.sv
sw_top.sv
sw_top_assertions.sv
tb_sw_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the switch testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sw_top -f filelist.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sw_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0
